/* ht_pkg.sv */
`default_nettype none

package ht_pkg;

  // ************************************************************************
  // widths and table geometry.
  // ************************************************************************
  localparam int KEY_WIDTH   = 32;
  localparam int VALUE_WIDTH = 16;

  // bucket word layout is built from this many ways.
  localparam int WAYS = 2;

  // ************************************************************************
  // command and result encodings.
  // ************************************************************************
  typedef enum logic [1:0] {
    OP_SEARCH = 2'd0,
    OP_INSERT = 2'd1,
    OP_DELETE = 2'd2
  } ht_opcode_t;

  typedef enum logic [1:0] {
    ST_OK        = 2'd0,
    ST_NOT_FOUND = 2'd1,
    ST_FULL      = 2'd2
  } ht_status_t;

  // command queue payload.
  typedef struct packed {
    ht_opcode_t             opcode;
    logic [KEY_WIDTH-1:0]   key;
    logic [VALUE_WIDTH-1:0] value;
  } ht_command_t;

  // result queue payload.
  typedef struct packed {
    ht_opcode_t             opcode;
    ht_status_t             status;
    logic [KEY_WIDTH-1:0]   key;
    logic [VALUE_WIDTH-1:0] value;
  } ht_result_t;

  // one entry of a bucket.
  typedef struct packed {
    logic                   valid;
    logic [KEY_WIDTH-1:0]   key;
    logic [VALUE_WIDTH-1:0] value;
  } ht_way_t;

endpackage

`default_nettype wire

/* ht_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module ht_fifo
#(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  payload_t               mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   push;
  logic                   pop;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // a full queue still takes a push when the head leaves in the same cycle.
  assign in_ready  = (count != COUNT_WIDTH'(DEPTH)) || out_ready;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk)
    begin
      if (push)
        mem[wr_ptr] <= in_data;
    end

  always_ff @(posedge clk)
    begin
      if (rst)
        begin
          wr_ptr <= '0;
          rd_ptr <= '0;
          count  <= '0;
        end
      else
        begin
          if (push)
            wr_ptr <= next_ptr(wr_ptr);
          if (pop)
            rd_ptr <= next_ptr(rd_ptr);
          if (push && !pop)
            count <= count + 1'b1;
          else if (pop && !push)
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* ht_bucket_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module ht_bucket_ram
#(
  parameter  int BUCKET_COUNT = 16,
  localparam int INDEX_WIDTH  = $clog2(BUCKET_COUNT)
)
(
  input  logic                                  clk,
  input  logic                                  rd_en,
  input  logic [INDEX_WIDTH-1:0]                rd_addr,
  output ht_pkg::ht_way_t [ht_pkg::WAYS-1:0]    rd_data,
  input  logic                                  wr_en,
  input  logic [INDEX_WIDTH-1:0]                wr_addr,
  input  ht_pkg::ht_way_t [ht_pkg::WAYS-1:0]    wr_data
);

  import ht_pkg::*;

  // one word per bucket, all ways side by side.
  ht_way_t [WAYS-1:0] mem [BUCKET_COUNT];

  always_ff @(posedge clk)
    begin
      if (wr_en)
        mem[wr_addr] <= wr_data;
    end

  // registered read; a same-address write in this cycle is not seen.
  always_ff @(posedge clk)
    begin
      if (rd_en)
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* ht_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module ht_engine
#(
  parameter  int BUCKET_COUNT = 16,
  localparam int INDEX_WIDTH  = $clog2(BUCKET_COUNT)
)
(
  input  logic                                  clk,
  input  logic                                  rst,

  input  logic                                  in_valid,
  output logic                                  in_ready,
  input  ht_pkg::ht_opcode_t                    in_opcode,
  input  logic [ht_pkg::KEY_WIDTH-1:0]          in_key,
  input  logic [ht_pkg::VALUE_WIDTH-1:0]        in_value,

  output logic                                  out_valid,
  input  logic                                  out_ready,
  output ht_pkg::ht_opcode_t                    out_opcode,
  output ht_pkg::ht_status_t                    out_status,
  output logic [ht_pkg::KEY_WIDTH-1:0]          out_key,
  output logic [ht_pkg::VALUE_WIDTH-1:0]        out_value,

  output logic                                  rd_en,
  output logic [INDEX_WIDTH-1:0]                rd_addr,
  input  ht_pkg::ht_way_t [ht_pkg::WAYS-1:0]    rd_data,
  output logic                                  wr_en,
  output logic [INDEX_WIDTH-1:0]                wr_addr,
  output ht_pkg::ht_way_t [ht_pkg::WAYS-1:0]    wr_data
);

  import ht_pkg::*;

  localparam int WAY_WIDTH = $clog2(WAYS);

  typedef enum logic [1:0] {
    CLEAR,
    IDLE,
    LOOKUP,
    RESPOND
  } state_t;

  state_t                 state;
  state_t                 state_next;
  logic [INDEX_WIDTH-1:0] clear_addr;

  ht_opcode_t             cmd_opcode;
  logic [KEY_WIDTH-1:0]   cmd_key;
  logic [VALUE_WIDTH-1:0] cmd_value;

  logic                   hit;
  logic                   free;
  logic [WAY_WIDTH-1:0]   hit_way;
  logic [WAY_WIDTH-1:0]   free_way;
  ht_way_t [WAYS-1:0]     new_bucket;
  logic                   bucket_write;
  ht_status_t             status;
  logic [VALUE_WIDTH-1:0] found_value;

  // xor of the four key bytes, cut to the index width.
  function automatic logic [INDEX_WIDTH-1:0] bucket_index(input logic [KEY_WIDTH-1:0] key);
    logic [7:0] folded;
    folded = key[31:24] ^ key[23:16] ^ key[15:8] ^ key[7:0];
    return folded[INDEX_WIDTH-1:0];
  endfunction

  // ************************************************************************
  // command intake and bucket read.
  // ************************************************************************
  assign in_ready = (state == IDLE);
  assign rd_en    = in_valid && in_ready;
  assign rd_addr  = bucket_index(in_key);

  always_ff @(posedge clk)
    begin
      if (rd_en)
        begin
          cmd_opcode <= in_opcode;
          cmd_key    <= in_key;
          cmd_value  <= in_value;
        end
    end

  // ************************************************************************
  // way match and bucket update.
  // ************************************************************************
  // rd_data stays put until the next read, so this also holds in RESPOND.
  always_comb
    begin
      hit      = 1'b0;
      free     = 1'b0;
      hit_way  = '0;
      free_way = '0;
      // walk downwards so the lowest way wins.
      for (int w = WAYS - 1; w >= 0; w--)
        begin
          if (rd_data[w].valid && (rd_data[w].key == cmd_key))
            begin
              hit     = 1'b1;
              hit_way = WAY_WIDTH'(w);
            end
          if (!rd_data[w].valid)
            begin
              free     = 1'b1;
              free_way = WAY_WIDTH'(w);
            end
        end
    end

  always_comb
    begin
      new_bucket   = rd_data;
      bucket_write = 1'b0;
      status       = ST_NOT_FOUND;
      found_value  = '0;
      case (cmd_opcode)
        OP_SEARCH:
          if (hit)
            begin
              status      = ST_OK;
              found_value = rd_data[hit_way].value;
            end
        OP_INSERT:
          if (hit)
            begin
              status                     = ST_OK;
              new_bucket[hit_way].value  = cmd_value;
              bucket_write               = 1'b1;
            end
          else if (free)
            begin
              status                     = ST_OK;
              new_bucket[free_way].valid = 1'b1;
              new_bucket[free_way].key   = cmd_key;
              new_bucket[free_way].value = cmd_value;
              bucket_write               = 1'b1;
            end
          else
            status = ST_FULL;
        OP_DELETE:
          if (hit)
            begin
              status                    = ST_OK;
              new_bucket[hit_way].valid = 1'b0;
              bucket_write              = 1'b1;
            end
        default:
          status = ST_NOT_FOUND;
      endcase
    end

  // the clear sweep owns the write port until the table is empty.
  assign wr_en   = (state == CLEAR) || ((state == LOOKUP) && bucket_write);
  assign wr_addr = (state == CLEAR) ? clear_addr : bucket_index(cmd_key);
  assign wr_data = (state == CLEAR) ? '0 : new_bucket;

  assign out_valid  = (state == LOOKUP) || (state == RESPOND);
  assign out_opcode = cmd_opcode;
  assign out_status = status;
  assign out_key    = cmd_key;
  assign out_value  = found_value;

  // ************************************************************************
  // sequencer.
  // ************************************************************************
  always_comb
    begin
      state_next = state;
      case (state)
        CLEAR:
          if (clear_addr == INDEX_WIDTH'(BUCKET_COUNT - 1))
            state_next = IDLE;
        IDLE:
          if (in_valid)
            state_next = LOOKUP;
        LOOKUP:
          state_next = out_ready ? IDLE : RESPOND;
        RESPOND:
          if (out_ready)
            state_next = IDLE;
        default:
          state_next = CLEAR;
      endcase
    end

  always_ff @(posedge clk)
    begin
      if (rst)
        begin
          state      <= CLEAR;
          clear_addr <= '0;
        end
      else
        begin
          state <= state_next;
          if (state == CLEAR)
            clear_addr <= clear_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* ht_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ht_top
#(
  parameter int BUCKET_COUNT = 16,
  parameter int FIFO_DEPTH   = 4
)
(
  input  logic                              clk,
  input  logic                              rst,

  input  logic                              cmd_valid,
  output logic                              cmd_ready,
  input  ht_pkg::ht_opcode_t                cmd_opcode,
  input  logic [ht_pkg::KEY_WIDTH-1:0]      cmd_key,
  input  logic [ht_pkg::VALUE_WIDTH-1:0]    cmd_value,

  output logic                              res_valid,
  input  logic                              res_ready,
  output ht_pkg::ht_opcode_t                res_opcode,
  output ht_pkg::ht_status_t                res_status,
  output logic [ht_pkg::KEY_WIDTH-1:0]      res_key,
  output logic [ht_pkg::VALUE_WIDTH-1:0]    res_value
);

  import ht_pkg::*;

  localparam int INDEX_WIDTH = $clog2(BUCKET_COUNT);

  ht_command_t            cmd_in_data;
  ht_command_t            cmd_out_data;
  ht_result_t             res_in_data;
  ht_result_t             res_out_data;

  logic                   eng_in_valid;
  logic                   eng_in_ready;
  logic                   eng_out_valid;
  logic                   eng_out_ready;
  ht_opcode_t             eng_out_opcode;
  ht_status_t             eng_out_status;
  logic [KEY_WIDTH-1:0]   eng_out_key;
  logic [VALUE_WIDTH-1:0] eng_out_value;

  logic                   rd_en;
  logic [INDEX_WIDTH-1:0] rd_addr;
  ht_way_t [WAYS-1:0]     rd_data;
  logic                   wr_en;
  logic [INDEX_WIDTH-1:0] wr_addr;
  ht_way_t [WAYS-1:0]     wr_data;

  assign cmd_in_data = '{opcode: cmd_opcode, key: cmd_key, value: cmd_value};

  ht_fifo
  #(
    .payload_t ( ht_command_t ),
    .DEPTH     ( FIFO_DEPTH   )
  ) u_cmd_fifo (
    .clk       ( clk          ),
    .rst       ( rst          ),
    .in_valid  ( cmd_valid    ),
    .in_ready  ( cmd_ready    ),
    .in_data   ( cmd_in_data  ),
    .out_valid ( eng_in_valid ),
    .out_ready ( eng_in_ready ),
    .out_data  ( cmd_out_data )
  );

  ht_engine
  #(
    .BUCKET_COUNT ( BUCKET_COUNT )
  ) u_engine (
    .clk        ( clk                ),
    .rst        ( rst                ),
    .in_valid   ( eng_in_valid       ),
    .in_ready   ( eng_in_ready       ),
    .in_opcode  ( cmd_out_data.opcode ),
    .in_key     ( cmd_out_data.key   ),
    .in_value   ( cmd_out_data.value ),
    .out_valid  ( eng_out_valid      ),
    .out_ready  ( eng_out_ready      ),
    .out_opcode ( eng_out_opcode     ),
    .out_status ( eng_out_status     ),
    .out_key    ( eng_out_key        ),
    .out_value  ( eng_out_value      ),
    .rd_en      ( rd_en              ),
    .rd_addr    ( rd_addr            ),
    .rd_data    ( rd_data            ),
    .wr_en      ( wr_en              ),
    .wr_addr    ( wr_addr            ),
    .wr_data    ( wr_data            )
  );

  ht_bucket_ram
  #(
    .BUCKET_COUNT ( BUCKET_COUNT )
  ) u_ram (
    .clk     ( clk     ),
    .rd_en   ( rd_en   ),
    .rd_addr ( rd_addr ),
    .rd_data ( rd_data ),
    .wr_en   ( wr_en   ),
    .wr_addr ( wr_addr ),
    .wr_data ( wr_data )
  );

  assign res_in_data = '{opcode: eng_out_opcode, status: eng_out_status,
                         key: eng_out_key, value: eng_out_value};

  ht_fifo
  #(
    .payload_t ( ht_result_t ),
    .DEPTH     ( FIFO_DEPTH  )
  ) u_res_fifo (
    .clk       ( clk           ),
    .rst       ( rst           ),
    .in_valid  ( eng_out_valid ),
    .in_ready  ( eng_out_ready ),
    .in_data   ( res_in_data   ),
    .out_valid ( res_valid     ),
    .out_ready ( res_ready     ),
    .out_data  ( res_out_data  )
  );

  assign res_opcode = res_out_data.opcode;
  assign res_status = res_out_data.status;
  assign res_key    = res_out_data.key;
  assign res_value  = res_out_data.value;

endmodule

`default_nettype wire

/* tb_ht.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ht;

  import ht_pkg::*;

  localparam int  HALF_PERIOD  = 50;
  localparam int  SAMPLE_DELAY = 40;
  localparam int  RESET_CYCLES = 16;
  localparam int  MAX_WAIT     = 200;
  localparam int  QUIET_CYCLES = 20;
  localparam int  MAX_PATTERNS = 64;
  localparam byte COMMENT_CHAR = 8'h23;

  logic                   clk;
  logic                   rst;
  logic                   cmd_valid;
  logic                   cmd_ready;
  ht_opcode_t             cmd_opcode;
  logic [KEY_WIDTH-1:0]   cmd_key;
  logic [VALUE_WIDTH-1:0] cmd_value;
  logic                   res_valid;
  logic                   res_ready;
  ht_opcode_t             res_opcode;
  ht_status_t             res_status;
  logic [KEY_WIDTH-1:0]   res_key;
  logic [VALUE_WIDTH-1:0] res_value;

  // one entry per pattern line, in file order.
  logic [1:0]             pat_opcode [MAX_PATTERNS];
  logic [KEY_WIDTH-1:0]   pat_key    [MAX_PATTERNS];
  logic [VALUE_WIDTH-1:0] pat_value  [MAX_PATTERNS];
  logic [1:0]             pat_status [MAX_PATTERNS];
  logic [VALUE_WIDTH-1:0] pat_expect [MAX_PATTERNS];
  int                     num_patterns;

  int                     value_errors;
  int                     other_errors;
  int                     result_count;

  ht_top u_dut (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .cmd_valid  ( cmd_valid  ),
    .cmd_ready  ( cmd_ready  ),
    .cmd_opcode ( cmd_opcode ),
    .cmd_key    ( cmd_key    ),
    .cmd_value  ( cmd_value  ),
    .res_valid  ( res_valid  ),
    .res_ready  ( res_ready  ),
    .res_opcode ( res_opcode ),
    .res_status ( res_status ),
    .res_key    ( res_key    ),
    .res_value  ( res_value  )
  );

  initial
    begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
    end

  // result side back-pressure, ready about 70% of the cycles.
  initial
    begin
      void'($urandom(32'h5829));
      res_ready = 1'b0;
      forever
        begin
          @(negedge clk);
          res_ready = ($urandom_range(99, 0) < 70);
        end
    end

  // ************************************************************************
  // pattern file.
  // ************************************************************************
  task automatic load_patterns();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f_opcode;
    logic [31:0] f_key;
    logic [31:0] f_value;
    logic [31:0] f_status;
    logic [31:0] f_expect;
    num_patterns = 0;
    fd = $fopen("ht_patterns.txt", "r");
    if (fd == 0)
      begin
        other_errors++;
        $display("cannot open ht_patterns.txt for reading");
        return;
      end
    while ($fgets(line, fd) != 0)
      begin
        fields = 0;
        if (line.len() > 0 && line[0] != COMMENT_CHAR)
          fields = $sscanf(line, "%h %h %h %h %h",
                           f_opcode, f_key, f_value, f_status, f_expect);
        if (fields == 5 && num_patterns < MAX_PATTERNS)
          begin
            pat_opcode[num_patterns] = f_opcode[1:0];
            pat_key[num_patterns]    = f_key;
            pat_value[num_patterns]  = f_value[VALUE_WIDTH-1:0];
            pat_status[num_patterns] = f_status[1:0];
            pat_expect[num_patterns] = f_expect[VALUE_WIDTH-1:0];
            num_patterns++;
          end
      end
    $fclose(fd);
    if (num_patterns == 0)
      begin
        other_errors++;
        $display("ht_patterns.txt holds no usable pattern lines");
      end
  endtask

  // ************************************************************************
  // command driver and result checker.
  // ************************************************************************
  task automatic send_commands();
    int waited;
    bit taken;
    for (int i = 0; i < num_patterns; i++)
      begin
        @(negedge clk);
        cmd_valid  = 1'b1;
        cmd_opcode = ht_opcode_t'(pat_opcode[i]);
        cmd_key    = pat_key[i];
        cmd_value  = pat_value[i];
        waited     = 0;
        taken      = 1'b0;
        // sample shortly before the rising edge that does the transfer.
        while (!taken && waited < MAX_WAIT)
          begin
            #(SAMPLE_DELAY);
            if (cmd_ready)
              taken = 1'b1;
            else
              begin
                waited++;
                @(negedge clk);
              end
          end
        if (!taken)
          begin
            other_errors++;
            $display("timeout at %0t: command %0d was not accepted within %0d cycles",
                     $time, i, MAX_WAIT);
            cmd_valid = 1'b0;
            return;
          end
      end
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic compare_result(input int idx);
    if (res_opcode != pat_opcode[idx])
      begin
        value_errors++;
        $display("error at %0t: res_opcode expected %0d got %0d (pattern %0d)",
                 $time, pat_opcode[idx], res_opcode, idx);
      end
    if (res_key != pat_key[idx])
      begin
        value_errors++;
        $display("error at %0t: res_key expected %h got %h (pattern %0d)",
                 $time, pat_key[idx], res_key, idx);
      end
    if (res_status != pat_status[idx])
      begin
        value_errors++;
        $display("error at %0t: res_status expected %0d got %0d (pattern %0d)",
                 $time, pat_status[idx], res_status, idx);
      end
    if (res_value != pat_expect[idx])
      begin
        value_errors++;
        $display("error at %0t: res_value expected %h got %h (pattern %0d)",
                 $time, pat_expect[idx], res_value, idx);
      end
  endtask

  task automatic collect_results();
    int waited;
    bit seen;
    for (int i = 0; i < num_patterns; i++)
      begin
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < MAX_WAIT)
          begin
            @(negedge clk);
            #(SAMPLE_DELAY);
            if (res_valid && res_ready)
              seen = 1'b1;
            else
              waited++;
          end
        if (!seen)
          begin
            other_errors++;
            $display("timeout at %0t: no result for pattern %0d within %0d cycles",
                     $time, i, MAX_WAIT);
            return;
          end
        compare_result(i);
        result_count++;
      end
  endtask

  // nothing may come out once every pattern has its result.
  task automatic check_quiet();
    for (int c = 0; c < QUIET_CYCLES; c++)
      begin
        @(negedge clk);
        #(SAMPLE_DELAY);
        if (res_valid)
          begin
            other_errors++;
            $display("extra result at %0t after the last pattern, key %h", $time, res_key);
            return;
          end
      end
  endtask

  // ************************************************************************
  // main sequence.
  // ************************************************************************
  initial
    begin
      rst          = 1'b1;
      cmd_valid    = 1'b0;
      cmd_opcode   = OP_SEARCH;
      cmd_key      = '0;
      cmd_value    = '0;
      value_errors = 0;
      other_errors = 0;
      result_count = 0;
      load_patterns();

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      if (res_valid)
        begin
          other_errors++;
          $display("res_valid is high at the end of reset");
        end
      rst = 1'b0;

      // commands queue up during the clear sweep.
      if (num_patterns > 0)
        fork
          send_commands();
          collect_results();
        join

      if (result_count == num_patterns && num_patterns > 0)
        check_quiet();
      else
        begin
          other_errors++;
          $display("got %0d results for %0d commands", result_count, num_patterns);
        end

      $display("results %0d of %0d, value errors %0d, other errors %0d",
               result_count, num_patterns, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
        $display("Simulation PASSED");
      else
        $display("Simulation FAILED");
      $finish;
    end

endmodule

`default_nettype wire

/* ht_patterns.txt */
# columns (hex): opcode key value expected_status expected_value
# opcode 0 search, 1 insert, 2 delete; status 0 ok, 1 not found, 2 full
0 00000001 0000 1 0000
2 00000002 0000 1 0000
0 04000000 0000 1 0000
1 00000001 1234 0 0000
0 00000001 0000 0 1234
1 00000001 abcd 0 0000
0 00000001 0000 0 abcd
1 04000000 1111 0 0000
1 04100000 2222 0 0000
0 04000000 0000 0 1111
0 04100000 0000 0 2222
1 00000014 3333 2 0000
0 00000014 0000 1 0000
2 04000000 0000 0 0000
0 04000000 0000 1 0000
0 04100000 0000 0 2222
1 00000014 3333 0 0000
0 00000014 0000 0 3333
1 04100000 4444 0 0000
0 04100000 0000 0 4444
2 04000000 0000 1 0000
1 0000abcd 5555 0 0000
1 12345678 6666 0 0000
0 0000abcd 0000 0 5555
0 12345678 0000 0 6666
2 00000001 0000 0 0000
0 00000001 0000 1 0000
0 00000014 0000 0 3333
0 0000abcd 0000 0 5555
0 00000007 0000 1 0000

/* compile.f */
ht_pkg.sv
ht_fifo.sv
ht_bucket_ram.sv
ht_engine.sv
ht_top.sv
tb_ht.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ns --top-module tb_ht \
		-f compile.f -o tb_ht
	@out="$$(./obj_dir/tb_ht)"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir
